//--- src/xfer_settings.svh
`ifndef XFER_SETTINGS_SVH
`define XFER_SETTINGS_SVH

// data word width of both streams.
`define XFER_WIDTH 8

// fifo depth, one slot stays unused.
`define XFER_DEPTH 8

// pointer and usedw width, log2 of the depth.
`define XFER_DLOG2 3

// apb bus widths.
`define XFER_APB_AW 4
`define XFER_APB_DW 32

// apb register byte offsets.
`define XFER_ADDR_DATA   4'h0
`define XFER_ADDR_STATUS 4'h4
`define XFER_ADDR_CTRL   4'h8

`endif

//--- src/xfer_pkg.sv
`include "xfer_settings.svh"

package xfer_pkg;

  typedef logic [`XFER_WIDTH-1:0] word_t;
  typedef logic [`XFER_DLOG2-1:0] ptr_t;
  typedef logic chan_t;

  typedef logic [`XFER_APB_AW-1:0] apb_addr_t;
  typedef logic [`XFER_APB_DW-1:0] apb_data_t;

  typedef struct packed {
    word_t data;
    logic  wrreq;
  } wr_req_t;

  typedef struct packed {
    logic full;
    ptr_t usedw;
  } wr_stat_t;

  // field order gives the DATA register layout.
  typedef struct packed {
    logic  valid;
    chan_t chan;
    word_t word;
  } merged_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
  } apb_rsp_t;

  typedef enum logic {
    IDLE,
    POP
  } merge_state_t;

endpackage

//--- src/async_fifo.sv
`include "xfer_settings.svh"

module async_fifo (
  input  xfer_pkg::word_t data,
  input  logic            wrclk,
  input  logic            wrreq,
  input  logic            rdclk,
  input  logic            rdreq,
  input  logic            aclr,
  output xfer_pkg::word_t q,
  output logic            rd_empty,
  output logic            rd_full,
  output logic            wr_empty,
  output logic            wr_full,
  output xfer_pkg::ptr_t  wrusedw,
  output xfer_pkg::ptr_t  rdusedw
);

  localparam xfer_pkg::ptr_t LAST_SLOT = xfer_pkg::ptr_t'(`XFER_DEPTH - 1);

  xfer_pkg::word_t mem [`XFER_DEPTH];

  xfer_pkg::ptr_t wr_ptr;
  xfer_pkg::ptr_t wr_ptr_next;
  xfer_pkg::ptr_t wr_gray;
  xfer_pkg::ptr_t rd_gray_s1;
  xfer_pkg::ptr_t rd_gray_s2;
  xfer_pkg::ptr_t rd_ptr_sync;
  xfer_pkg::ptr_t wr_diff;

  xfer_pkg::ptr_t rd_ptr;
  xfer_pkg::ptr_t rd_ptr_next;
  xfer_pkg::ptr_t rd_gray;
  xfer_pkg::ptr_t wr_gray_s1;
  xfer_pkg::ptr_t wr_gray_s2;
  xfer_pkg::ptr_t wr_ptr_sync;
  xfer_pkg::ptr_t rd_diff;

  function automatic xfer_pkg::ptr_t bin2gray(input xfer_pkg::ptr_t b);
    return b ^ (b >> 1);
  endfunction

  function automatic xfer_pkg::ptr_t gray2bin(input xfer_pkg::ptr_t g);
    xfer_pkg::ptr_t b;
    b[`XFER_DLOG2-1] = g[`XFER_DLOG2-1];
    for (int i = `XFER_DLOG2 - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  assign wr_ptr_next = wr_ptr + 1'b1;
  assign rd_ptr_next = rd_ptr + 1'b1;

  // write side.
  always_ff @(posedge wrclk or negedge aclr) begin
    if (!aclr) begin
      wr_ptr     <= '0;
      wr_gray    <= '0;
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
      wrusedw    <= '0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
      wrusedw    <= wr_diff;
      if (wrreq) begin
        wr_ptr  <= wr_ptr_next;
        wr_gray <= bin2gray(wr_ptr_next);
      end
    end
  end

  always_ff @(posedge wrclk) begin
    if (wrreq) begin
      mem[wr_ptr] <= data;
    end
  end

  // read side.
  always_ff @(posedge rdclk or negedge aclr) begin
    if (!aclr) begin
      rd_ptr     <= '0;
      rd_gray    <= '0;
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
      rdusedw    <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
      rdusedw    <= rd_diff;
      if (rdreq) begin
        rd_ptr  <= rd_ptr_next;
        rd_gray <= bin2gray(rd_ptr_next);
      end
    end
  end

  // q follows the head slot every cycle, so a pop shows one cycle later.
  always_ff @(posedge rdclk) begin
    q <= mem[rd_ptr];
  end

  assign rd_ptr_sync = gray2bin(rd_gray_s2);
  assign wr_ptr_sync = gray2bin(wr_gray_s2);

  // modulo differences, wrap comes for free at this width.
  assign wr_diff = wr_ptr - rd_ptr_sync;
  assign rd_diff = wr_ptr_sync - rd_ptr;

  assign wr_empty = (wr_diff == '0);
  assign wr_full  = (wr_diff == LAST_SLOT);
  assign rd_empty = (rd_diff == '0);
  assign rd_full  = (rd_diff == LAST_SLOT);

endmodule

//--- src/chan_merge.sv
module chan_merge (
  input  logic              rdclk,
  input  logic              aclr,
  input  logic [1:0]        empty,
  input  xfer_pkg::word_t   q0,
  input  xfer_pkg::word_t   q1,
  input  logic [1:0]        enable,
  input  logic              take,
  output logic [1:0]        rdreq,
  output xfer_pkg::merged_t head
);

  xfer_pkg::merge_state_t state;
  xfer_pkg::merge_state_t state_next;
  xfer_pkg::chan_t        last;
  xfer_pkg::chan_t        pick;
  logic [1:0]             ready;
  logic                   start;

  logic                   hold_valid;
  xfer_pkg::chan_t        hold_chan;
  xfer_pkg::word_t        hold_word;

  assign ready = enable & ~empty;

  // on a tie serve the channel after the last one.
  always_comb begin
    if (ready == 2'b11) begin
      pick = ~last;
    end else if (ready[1]) begin
      pick = 1'b1;
    end else begin
      pick = 1'b0;
    end
  end

  assign start = (state == xfer_pkg::IDLE) && !hold_valid && (ready != 2'b00);
  assign rdreq = start ? (2'b01 << pick) : 2'b00;

  always_comb begin
    case (state)
      xfer_pkg::IDLE: state_next = start ? xfer_pkg::POP : xfer_pkg::IDLE;
      xfer_pkg::POP:  state_next = xfer_pkg::IDLE;
      default:        state_next = xfer_pkg::IDLE;
    endcase
  end

  // last starts at 1 so channel 0 wins the first tie.
  always_ff @(posedge rdclk or negedge aclr) begin
    if (!aclr) begin
      state <= xfer_pkg::IDLE;
      last  <= 1'b1;
    end else begin
      state <= state_next;
      if (start) begin
        last <= pick;
      end
    end
  end

  always_ff @(posedge rdclk or negedge aclr) begin
    if (!aclr) begin
      hold_valid <= 1'b0;
    end else if (state == xfer_pkg::POP) begin
      hold_valid <= 1'b1;
    end else if (take) begin
      hold_valid <= 1'b0;
    end
  end

  // in POP, last is the channel that was just popped.
  always_ff @(posedge rdclk) begin
    if (state == xfer_pkg::POP) begin
      hold_chan <= last;
      hold_word <= (last == 1'b1) ? q1 : q0;
    end
  end

  assign head.valid = hold_valid;
  assign head.chan  = hold_chan;
  assign head.word  = hold_word;

endmodule

//--- src/apb_regs.sv
`include "xfer_settings.svh"

module apb_regs (
  input  logic               rdclk,
  input  logic               aclr,
  input  xfer_pkg::apb_req_t req,
  output xfer_pkg::apb_rsp_t rsp,
  input  xfer_pkg::merged_t  head,
  input  xfer_pkg::ptr_t     usedw0,
  input  xfer_pkg::ptr_t     usedw1,
  output logic [1:0]         enable,
  output logic               take
);

  logic                access;
  logic                rd_data;
  logic                wr_ctrl;
  xfer_pkg::apb_data_t rdata;

  // access phase only, no wait states.
  assign access  = req.psel & req.penable;
  assign rd_data = access & ~req.pwrite & (req.paddr == `XFER_ADDR_DATA);
  assign wr_ctrl = access & req.pwrite & (req.paddr == `XFER_ADDR_CTRL);

  always_ff @(posedge rdclk or negedge aclr) begin
    if (!aclr) begin
      enable <= 2'b11;
      take   <= 1'b0;
    end else begin
      take <= rd_data & head.valid;
      if (wr_ctrl) begin
        enable <= req.pwdata[1:0];
      end
    end
  end

  always_comb begin
    rdata = '0;
    case (req.paddr)
      `XFER_ADDR_DATA: begin
        rdata[$bits(xfer_pkg::merged_t)-1:0] = head;
      end
      `XFER_ADDR_STATUS: begin
        rdata[`XFER_DLOG2-1:0]  = usedw0;
        rdata[4 +: `XFER_DLOG2] = usedw1;
        rdata[8]                = head.valid;
      end
      `XFER_ADDR_CTRL: begin
        rdata[1:0] = enable;
      end
      default: begin
        rdata = '0;
      end
    endcase
  end

  assign rsp.prdata = rdata;
  assign rsp.pready = 1'b1;

endmodule

//--- src/xfer_top.sv
module xfer_top (
  input  logic               wrclk,
  input  logic               rdclk,
  input  logic               aclr,
  input  xfer_pkg::wr_req_t  wr0,
  input  xfer_pkg::wr_req_t  wr1,
  output xfer_pkg::wr_stat_t st0,
  output xfer_pkg::wr_stat_t st1,
  input  xfer_pkg::apb_req_t apb_req,
  output xfer_pkg::apb_rsp_t apb_rsp
);

  logic [1:0]        empty;
  logic [1:0]        rdreq;
  logic [1:0]        enable;
  logic              take;
  xfer_pkg::word_t   q0;
  xfer_pkg::word_t   q1;
  xfer_pkg::ptr_t    rdusedw0;
  xfer_pkg::ptr_t    rdusedw1;
  xfer_pkg::merged_t head;

  async_fifo u_fifo0 (
    .data     (wr0.data),
    .wrclk    (wrclk),
    .wrreq    (wr0.wrreq),
    .rdclk    (rdclk),
    .rdreq    (rdreq[0]),
    .aclr     (aclr),
    .q        (q0),
    .rd_empty (empty[0]),
    .rd_full  (),
    .wr_empty (),
    .wr_full  (st0.full),
    .wrusedw  (st0.usedw),
    .rdusedw  (rdusedw0)
  );

  async_fifo u_fifo1 (
    .data     (wr1.data),
    .wrclk    (wrclk),
    .wrreq    (wr1.wrreq),
    .rdclk    (rdclk),
    .rdreq    (rdreq[1]),
    .aclr     (aclr),
    .q        (q1),
    .rd_empty (empty[1]),
    .rd_full  (),
    .wr_empty (),
    .wr_full  (st1.full),
    .wrusedw  (st1.usedw),
    .rdusedw  (rdusedw1)
  );

  chan_merge u_merge (
    .rdclk  (rdclk),
    .aclr   (aclr),
    .empty  (empty),
    .q0     (q0),
    .q1     (q1),
    .enable (enable),
    .take   (take),
    .rdreq  (rdreq),
    .head   (head)
  );

  apb_regs u_regs (
    .rdclk  (rdclk),
    .aclr   (aclr),
    .req    (apb_req),
    .rsp    (apb_rsp),
    .head   (head),
    .usedw0 (rdusedw0),
    .usedw1 (rdusedw1),
    .enable (enable),
    .take   (take)
  );

endmodule

//--- verif/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

localparam int WAIT_LIMIT = 100;

task automatic stop_run();
  $display("Simulation FAILED");
  $fatal(1, "stopping at the first error");
endtask

task automatic check_merged(input xfer_pkg::merged_t got, input xfer_pkg::merged_t exp,
                            input string what);
  if (got !== exp) begin
    $display("FAIL %0t: %s got %b/%0d/%02h, expected %b/%0d/%02h", $time, what,
             got.valid, got.chan, got.word, exp.valid, exp.chan, exp.word);
    stop_run();
  end
endtask

task automatic check_usedw(input xfer_pkg::ptr_t got, input xfer_pkg::ptr_t exp,
                           input string what);
  if (got !== exp) begin
    $display("FAIL %0t: %s got %0d, expected %0d", $time, what, got, exp);
    stop_run();
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    $display("FAIL %0t: %s got %b, expected %b", $time, what, got, exp);
    stop_run();
  end
endtask

task automatic check_data(input xfer_pkg::apb_data_t got, input xfer_pkg::apb_data_t exp,
                          input string what);
  if (got !== exp) begin
    $display("FAIL %0t: %s got %08h, expected %08h", $time, what, got, exp);
    stop_run();
  end
endtask

// write status is sampled on the falling wrclk edge.
task automatic wait_wr_stat(input xfer_pkg::chan_t chan, input logic full,
                            input xfer_pkg::ptr_t usedw);
  xfer_pkg::wr_stat_t stat;
  int cnt;
  cnt = 0;
  @(negedge wrclk);
  stat = chan ? st1 : st0;
  while (stat.full !== full || stat.usedw !== usedw) begin
    cnt++;
    if (cnt > WAIT_LIMIT) begin
      $display("Timed out waiting for channel %0d to show full %0b and usedw %0d",
               chan, full, usedw);
      stop_run();
    end
    @(negedge wrclk);
    stat = chan ? st1 : st0;
  end
endtask

task automatic wait_status(input xfer_pkg::apb_data_t exp);
  xfer_pkg::apb_data_t rd;
  int cnt;
  cnt = 0;
  apb_read(`XFER_ADDR_STATUS, rd);
  while (rd !== exp) begin
    cnt++;
    if (cnt > WAIT_LIMIT) begin
      $display("Timed out waiting for STATUS %08h, last read %08h", exp, rd);
      stop_run();
    end
    apb_read(`XFER_ADDR_STATUS, rd);
  end
endtask

// polls DATA until the holding register is valid.
task automatic read_head(output xfer_pkg::merged_t head);
  xfer_pkg::apb_data_t rd;
  int cnt;
  cnt = 0;
  apb_read(`XFER_ADDR_DATA, rd);
  while (rd[9] !== 1'b1) begin
    cnt++;
    if (cnt > WAIT_LIMIT) begin
      $display("Timed out waiting for a valid word in the DATA register");
      stop_run();
    end
    apb_read(`XFER_ADDR_DATA, rd);
  end
  head = xfer_pkg::merged_t'(rd[$bits(xfer_pkg::merged_t)-1:0]);
endtask

`endif

//--- verif/tb_xfer.sv
`include "xfer_settings.svh"

module tb_xfer;

  logic               wrclk;
  logic               rdclk;
  logic               aclr;
  xfer_pkg::wr_req_t  wr0;
  xfer_pkg::wr_req_t  wr1;
  xfer_pkg::wr_stat_t st0;
  xfer_pkg::wr_stat_t st1;
  xfer_pkg::apb_req_t apb_req;
  xfer_pkg::apb_rsp_t apb_rsp;

  integer seed;

  // expected words of each channel with the oldest first.
  xfer_pkg::word_t model0[$];
  xfer_pkg::word_t model1[$];

  xfer_top DUT (
    .wrclk   (wrclk),
    .rdclk   (rdclk),
    .aclr    (aclr),
    .wr0     (wr0),
    .wr1     (wr1),
    .st0     (st0),
    .st1     (st1),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  `include "tb_checks.svh"

  initial begin
    rdclk = 1'b0;
    forever #20 rdclk = ~rdclk;
  end

  initial begin
    wrclk = 1'b0;
    forever #14 wrclk = ~wrclk;
  end

  // one setup and one access phase with the read data taken mid-cycle.
  task automatic apb_access(input logic write, input xfer_pkg::apb_addr_t addr,
                            input xfer_pkg::apb_data_t wdata,
                            output xfer_pkg::apb_data_t rdata);
    int cnt;
    cnt = 0;
    @(posedge rdclk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge rdclk);
    apb_req.penable <= 1'b1;
    @(negedge rdclk);
    while (apb_rsp.pready !== 1'b1) begin
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        $display("Timed out waiting for pready on the APB bus");
        stop_run();
      end
      @(negedge rdclk);
    end
    rdata = apb_rsp.prdata;
    @(posedge rdclk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic apb_write(input xfer_pkg::apb_addr_t addr, input xfer_pkg::apb_data_t data);
    xfer_pkg::apb_data_t unused;
    apb_access(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input xfer_pkg::apb_addr_t addr, output xfer_pkg::apb_data_t data);
    apb_access(1'b0, addr, '0, data);
  endtask

  task automatic push(input xfer_pkg::chan_t chan, input xfer_pkg::word_t word);
    int cnt;
    cnt = 0;
    @(negedge wrclk);
    while ((chan ? st1.full : st0.full) !== 1'b0) begin
      cnt++;
      if (cnt > WAIT_LIMIT) begin
        $display("Timed out waiting for channel %0d to leave full", chan);
        stop_run();
      end
      @(negedge wrclk);
    end
    @(posedge wrclk);
    if (chan) begin
      wr1.data  <= word;
      wr1.wrreq <= 1'b1;
      model1.push_back(word);
    end else begin
      wr0.data  <= word;
      wr0.wrreq <= 1'b1;
      model0.push_back(word);
    end
    @(posedge wrclk);
    if (chan) begin
      wr1.wrreq <= 1'b0;
    end else begin
      wr0.wrreq <= 1'b0;
    end
  endtask

  // per-channel order holds while the interleave between channels is free.
  task automatic drain(input int n);
    xfer_pkg::merged_t got;
    xfer_pkg::merged_t exp;
    for (int i = 0; i < n; i++) begin
      read_head(got);
      if ((got.chan ? model1.size() : model0.size()) == 0) begin
        $display("A word arrived tagged for channel %0d, which has nothing pending", got.chan);
        stop_run();
      end
      exp.valid = 1'b1;
      exp.chan  = got.chan;
      exp.word  = got.chan ? model1.pop_front() : model0.pop_front();
      check_merged(got, exp, "drained word");
    end
  endtask

  task automatic test_reset();
    xfer_pkg::apb_data_t rd;
    apb_read(`XFER_ADDR_DATA, rd);
    check_bit(rd[9], 1'b0, "DATA valid after reset");
    apb_read(`XFER_ADDR_STATUS, rd);
    check_data(rd, 32'h0, "STATUS after reset");
    apb_read(`XFER_ADDR_CTRL, rd);
    check_data(rd, 32'h3, "CTRL after reset");
    @(negedge wrclk);
    check_bit(st0.full, 1'b0, "channel 0 full after reset");
    check_bit(st1.full, 1'b0, "channel 1 full after reset");
  endtask

  task automatic test_single();
    for (int i = 0; i < 6; i++) begin
      push(1'b0, xfer_pkg::word_t'($random(seed)));
    end
    drain(6);
  endtask

  task automatic test_both();
    xfer_pkg::word_t w0[5];
    xfer_pkg::word_t w1[5];
    for (int i = 0; i < 5; i++) begin
      w0[i] = xfer_pkg::word_t'($random(seed));
      w1[i] = xfer_pkg::word_t'($random(seed));
    end
    fork
      for (int i = 0; i < 5; i++) push(1'b0, w0[i]);
      for (int i = 0; i < 5; i++) push(1'b1, w1[i]);
    join
    drain(10);
    wait_status(32'h0);
  endtask

  task automatic test_mask_fill();
    xfer_pkg::apb_data_t rd;
    apb_write(`XFER_ADDR_CTRL, 32'h1);
    for (int i = 0; i < 7; i++) begin
      push(1'b1, xfer_pkg::word_t'($random(seed)));
    end
    wait_wr_stat(1'b1, 1'b1, 3'd7);
    wait_status(32'h70);
    apb_read(`XFER_ADDR_STATUS, rd);
    check_usedw(rd[6:4], 3'd7, "STATUS channel 1 usedw");
    apb_read(`XFER_ADDR_DATA, rd);
    check_bit(rd[9], 1'b0, "DATA valid with channel 1 masked");
  endtask

  task automatic test_unmask_drain();
    xfer_pkg::apb_data_t rd;
    apb_write(`XFER_ADDR_CTRL, 32'h3);
    drain(7);
    wait_wr_stat(1'b1, 1'b0, 3'd0);
    wait_wr_stat(1'b0, 1'b0, 3'd0);
    wait_status(32'h0);
    apb_read(`XFER_ADDR_CTRL, rd);
    check_data(rd, 32'h3, "CTRL after unmask");
  endtask

  initial begin
    seed    = 32'haa2d_66f8;
    aclr    <= 1'b0;
    wr0     <= '0;
    wr1     <= '0;
    apb_req <= '0;
    repeat (2) @(posedge rdclk);
    aclr <= 1'b1;
    repeat (2) @(posedge rdclk);
    test_reset();
    test_single();
    test_both();
    test_mask_fill();
    test_unmask_drain();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- all.f
+incdir+src
+incdir+verif
src/xfer_pkg.sv
src/async_fifo.sv
src/chan_merge.sv
src/apb_regs.sv
src/xfer_top.sv
verif/tb_xfer.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_xfer -f all.f || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_xfer 2>&1)
echo "$out"
echo "$out" | grep -qx "Simulation PASSED" && exit 0 || exit 1
